// File: design/audioPkg.sv
// Sample and mixed-sample types, I2S frame constants
`default_nettype none

package audioPkg;

	// ----------------------------------------
	// Sample formats
	// ----------------------------------------

	// Signed PCM word, stored low byte first in flash
	typedef logic signed [15:0] sampleT;

	// Exact sum of up to 256 channels never overflows this
	typedef logic signed [23:0] mixT;

	// ----------------------------------------
	// I2S framing
	// ----------------------------------------

	// Bits per slot, two slots per frame
	localparam int frameBits = 32;

endpackage

`default_nettype wire

// File: design/flashPkg.sv
// SPI flash command, byte address type and default channel count
`default_nettype none

package flashPkg;

	// ----------------------------------------
	// SPI flash access
	// ----------------------------------------

	// 24-bit byte address, sent MSB first after the command
	typedef logic [23:0] flashAddrT;

	// Plain read, no dummy cycles
	localparam logic [7:0] readCmd = 8'h03;

	// ----------------------------------------
	// Subsystem size
	// ----------------------------------------

	// BGM plus two effects, one chip each
	localparam int chanNum = 3;

endpackage

`default_nettype wire

// File: design/flashReader.sv
// SPI flash read engine streaming 16-bit samples of one chip over valid/ready
`timescale 1ns/100ps
`default_nettype none

module flashReader #(
	parameter int pSckDiv = 1
)(
	input  logic               sClk,
	input  logic               rstN,
	input  logic               play,
	input  flashPkg::flashAddrT startAddr,
	input  flashPkg::flashAddrT endAddr,
	input  logic               flashMiso,
	input  logic               sampleReady,
	output logic               flashSck,
	output logic               flashMosi,
	output logic               flashCsN,
	output logic               busy,
	output logic               sampleValid,
	output audioPkg::sampleT   sample
);
	import flashPkg::*;

	typedef enum logic [2:0] {stIdle, stCommand, stAddress, stData, stHold} stateT;

	// Divider width, at least one bit
	localparam int divW = (pSckDiv > 1) ? $clog2(pSckDiv) : 1;

	stateT           state;
	logic [divW-1:0] divCnt;
	logic [4:0]      bitCnt;
	logic [31:0]     txShift;
	logic [15:0]     rxShift;
	flashAddrT       curAddr;
	logic            sckTick;
	logic            lastSample;

	// SCK toggles on every terminal count
	assign sckTick = (divCnt == divW'(pSckDiv - 1));

	// High byte of the current sample sits at or past endAddr
	assign lastSample = (curAddr + 24'd1 >= endAddr);

	// Command and address go out MSB first, zeros afterwards
	assign flashMosi = txShift[31];

	// ----------------------------------------
	// Read FSM
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (!rstN)
		begin
			state       <= stIdle;
			flashCsN    <= 1'b1;
			flashSck    <= 1'b0;
			busy        <= 1'b0;
			sampleValid <= 1'b0;
			divCnt      <= '0;
			bitCnt      <= '0;
			txShift     <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					// CS drops the cycle after play
					if (play)
					begin
						state    <= stCommand;
						flashCsN <= 1'b0;
						busy     <= 1'b1;
						txShift  <= {readCmd, startAddr};
						divCnt   <= '0;
						bitCnt   <= '0;
					end
				end
				stCommand, stAddress, stData:
				begin
					divCnt <= sckTick ? '0 : divCnt + 1'b1;
					if (sckTick)
					begin
						flashSck <= ~flashSck;
						if (!flashSck)
						begin
							// Mode 0, sample MISO on the rising edge
							rxShift <= {rxShift[14:0], flashMiso};
						end
						else
						begin
							// Falling edge closes one bit period
							bitCnt <= bitCnt + 5'd1;
							if (state != stData)
								txShift <= {txShift[30:0], 1'b0};
							if (state == stCommand && bitCnt == 5'd7)
								state <= stAddress;
							if (state == stAddress && bitCnt == 5'd31)
								state <= stData;
							if (state == stData && bitCnt == 5'd15)
							begin
								// Two bytes in, low byte came first
								state       <= stHold;
								bitCnt      <= '0;
								sampleValid <= 1'b1;
								sample      <= {rxShift[7:0], rxShift[15:8]};
							end
						end
					end
				end
				stHold:
				begin
					// SCK parked low, CS held, until the mixer takes it
					if (sampleReady)
					begin
						sampleValid <= 1'b0;
						curAddr     <= curAddr + 24'd2;
						divCnt      <= '0;
						if (lastSample)
						begin
							state    <= stIdle;
							flashCsN <= 1'b1;
							busy     <= 1'b0;
						end
						else
							state <= stData;
					end
				end
				default:
					state <= stIdle;
			endcase

			// Address tracks the low byte of the next sample
			if (state == stIdle && play)
				curAddr <= startAddr;
		end
	end

endmodule

`default_nettype wire

// File: design/sampleMixer.sv
// Adder combining the samples of busy channels into one mixed stream
`timescale 1ns/100ps
`default_nettype none

module sampleMixer #(
	parameter int pChanNum = flashPkg::chanNum
)(
	input  logic                                        sClk,
	input  logic                                        rstN,
	input  logic [pChanNum-1:0]                         busy,
	input  logic [pChanNum-1:0]                         sampleValid,
	input  logic [pChanNum*$bits(audioPkg::sampleT)-1:0] samples,
	input  logic                                        fifoReady,
	output logic [pChanNum-1:0]                         sampleReady,
	output logic                                        mixValid,
	output audioPkg::mixT                               mix
);
	import audioPkg::*;

	localparam int sampleW = $bits(sampleT);

	logic anyBusy;
	logic allValid;
	logic outFree;
	logic accept;
	mixT  sum;

	assign anyBusy = |busy;
	// Idle channels never hold up the others
	assign allValid = &(sampleValid | ~busy);
	// Output stage empty or draining into the FIFO this cycle
	assign outFree = !mixValid || fifoReady;
	assign accept  = anyBusy && allValid && outFree;

	// Common ready keeps the channels aligned
	assign sampleReady = {pChanNum{accept}};

	// Sign-extended sum, idle channels add zero
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < pChanNum; i++)
			if (busy[i])
				sum = sum + mixT'(sampleT'(samples[i*sampleW +: sampleW]));
	end

	always_ff @(posedge sClk)
	begin
		if (!rstN)
			mixValid <= 1'b0;
		else if (accept)
			mixValid <= 1'b1;
		else if (fifoReady)
			mixValid <= 1'b0;
	end

	always_ff @(posedge sClk)
	begin
		if (accept)
			mix <= sum;
	end

endmodule

`default_nettype wire

// File: design/asyncFifo.sv
// Dual-clock FIFO with Gray-coded pointers and a type-parameter payload
`timescale 1ns/100ps
`default_nettype none

module asyncFifo #(
	parameter int  pFifoDepth = 16,
	parameter type payloadT   = logic [7:0]
)(
	input  logic    wrClk,
	input  logic    rdClk,
	input  logic    rstN,
	input  logic    wrValid,
	input  payloadT wrData,
	input  logic    pop,
	output logic    wrReady,
	output payloadT rdData,
	output logic    rdValid
);
	// Extra MSB tells full from empty, depth of 4 or more
	localparam int ptrW = $clog2(pFifoDepth);

	payloadT     mem [pFifoDepth];
	logic [ptrW:0] wrBin;
	logic [ptrW:0] wrGray;
	logic [ptrW:0] rdBin;
	logic [ptrW:0] rdGray;
	logic [ptrW:0] wrBinNext;
	logic [ptrW:0] rdBinNext;
	logic [ptrW:0] rdGraySync1;
	logic [ptrW:0] rdGraySync2;
	logic [ptrW:0] wrGraySync1;
	logic [ptrW:0] wrGraySync2;
	logic          wrEn;
	logic          rdEn;

	assign wrEn      = wrValid && wrReady;
	assign rdEn      = pop && rdValid;
	assign wrBinNext = wrBin + 1'b1;
	assign rdBinNext = rdBin + 1'b1;

	// ----------------------------------------
	// Write side
	// ----------------------------------------
	always_ff @(posedge wrClk)
	begin
		if (!rstN)
		begin
			wrBin       <= '0;
			wrGray      <= '0;
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
			if (wrEn)
			begin
				wrBin  <= wrBinNext;
				wrGray <= wrBinNext ^ (wrBinNext >> 1);
			end
		end
	end

	always_ff @(posedge wrClk)
	begin
		if (wrEn)
			mem[wrBin[ptrW-1:0]] <= wrData;
	end

	// Full when the top two Gray bits differ and the rest match
	assign wrReady = (wrGray != {~rdGraySync2[ptrW:ptrW-1], rdGraySync2[ptrW-2:0]});

	// ----------------------------------------
	// Read side
	// ----------------------------------------
	always_ff @(posedge rdClk)
	begin
		if (!rstN)
		begin
			rdBin       <= '0;
			rdGray      <= '0;
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end
		else
		begin
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
			if (rdEn)
			begin
				rdBin  <= rdBinNext;
				rdGray <= rdBinNext ^ (rdBinNext >> 1);
			end
		end
	end

	// Head word shows before pop
	assign rdValid = (rdGray != wrGraySync2);
	assign rdData  = mem[rdBin[ptrW-1:0]];

endmodule

`default_nettype wire

// File: design/i2sTransmitter.sv
// I2S clock generator and serialiser of mixed samples, one FIFO pop per frame
`timescale 1ns/100ps
`default_nettype none

module i2sTransmitter (
	input  logic          mClk,
	input  logic          rstN,
	input  logic          rdValid,
	input  audioPkg::mixT rdData,
	output logic          pop,
	output logic          i2sBclk,
	output logic          i2sLrclk,
	output logic          i2sData
);
	import audioPkg::*;

	// Bit slots per frame index, two mClk phase bits below
	localparam int slotW = $clog2(2 * frameBits);
	localparam int padW  = frameBits - $bits(mixT);

	logic [slotW+1:0]     cnt;
	logic [slotW-1:0]     slotNext;
	logic [frameBits-1:0] frameWord;
	logic [frameBits-1:0] shiftReg;

	// Slot entered at the coming BCLK falling edge
	assign slotNext = cnt[slotW+1:2] + 1'b1;

	always_ff @(posedge mClk)
	begin
		if (!rstN)
		begin
			cnt       <= '0;
			pop       <= 1'b0;
			i2sBclk   <= 1'b0;
			i2sLrclk  <= 1'b0;
			i2sData   <= 1'b0;
			frameWord <= '0;
			shiftReg  <= '0;
		end
		else
		begin
			cnt <= cnt + 1'b1;

			// One pop at the start of every frame
			pop <= (cnt == '1);
			if (pop)
				frameWord <= rdValid ? {rdData, {padW{1'b0}}} : '0;

			// BCLK is mClk/4, high in phases 2 and 3
			if (cnt[1:0] == 2'd1)
				i2sBclk <= 1'b1;

			// ----------------------------------------
			// Falling BCLK edge
			// ----------------------------------------
			if (cnt[1:0] == 2'd3)
			begin
				i2sBclk  <= 1'b0;
				// Left slot low, right slot high
				i2sLrclk <= slotNext[slotW-1];
				// MSB one BCLK after LRCLK moves, same word both slots
				if (slotNext[slotW-2:0] == 1)
				begin
					i2sData  <= frameWord[frameBits-1];
					shiftReg <= frameWord << 1;
				end
				else
				begin
					i2sData  <= shiftReg[frameBits-1];
					shiftReg <= shiftReg << 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/audioTxBlock.sv
// Top level of the flash readers, mixer, clock-crossing FIFO and I2S transmitter
`timescale 1ns/100ps
`default_nettype none

module audioTxBlock #(
	parameter int pChanNum   = flashPkg::chanNum,
	parameter int pSckDiv    = 1,
	parameter int pFifoDepth = 16
)(
	input  logic                               sClk,
	input  logic                               mClk,
	input  logic                               rstN,
	input  logic [pChanNum-1:0]                play,
	input  flashPkg::flashAddrT [pChanNum-1:0] startAddr,
	input  flashPkg::flashAddrT [pChanNum-1:0] endAddr,
	output logic [pChanNum-1:0]                busy,
	output logic [pChanNum-1:0]                flashSck,
	output logic [pChanNum-1:0]                flashMosi,
	input  logic [pChanNum-1:0]                flashMiso,
	output logic [pChanNum-1:0]                flashCsN,
	output logic                               i2sBclk,
	output logic                               i2sLrclk,
	output logic                               i2sData
);
	import audioPkg::*;

	localparam int sampleW = $bits(sampleT);

	logic [pChanNum-1:0]         sampleValid;
	logic [pChanNum-1:0]         sampleReady;
	logic [pChanNum*sampleW-1:0] samples;
	logic                        mixValid;
	mixT                         mix;
	logic                        fifoReady;
	logic                        rdValid;
	mixT                         rdData;
	logic                        pop;

	// ----------------------------------------
	// One reader per flash chip
	// ----------------------------------------
	for (genvar ch = 0; ch < pChanNum; ch++)
	begin : genReader
		flashReader #(
			.pSckDiv(pSckDiv)
		) u_flashReader (
			.sClk(sClk),
			.rstN(rstN),
			.play(play[ch]),
			.startAddr(startAddr[ch]),
			.endAddr(endAddr[ch]),
			.flashMiso(flashMiso[ch]),
			.sampleReady(sampleReady[ch]),
			.flashSck(flashSck[ch]),
			.flashMosi(flashMosi[ch]),
			.flashCsN(flashCsN[ch]),
			.busy(busy[ch]),
			.sampleValid(sampleValid[ch]),
			.sample(samples[ch*sampleW +: sampleW])
		);
	end

	sampleMixer #(
		.pChanNum(pChanNum)
	) u_sampleMixer (
		.sClk(sClk),
		.rstN(rstN),
		.busy(busy),
		.sampleValid(sampleValid),
		.samples(samples),
		.fifoReady(fifoReady),
		.sampleReady(sampleReady),
		.mixValid(mixValid),
		.mix(mix)
	);

	// sClk to mClk crossing
	asyncFifo #(
		.pFifoDepth(pFifoDepth),
		.payloadT(mixT)
	) u_asyncFifo (
		.wrClk(sClk),
		.rdClk(mClk),
		.rstN(rstN),
		.wrValid(mixValid),
		.wrData(mix),
		.pop(pop),
		.wrReady(fifoReady),
		.rdData(rdData),
		.rdValid(rdValid)
	);

	i2sTransmitter u_i2sTransmitter (
		.mClk(mClk),
		.rstN(rstN),
		.rdValid(rdValid),
		.rdData(rdData),
		.pop(pop),
		.i2sBclk(i2sBclk),
		.i2sLrclk(i2sLrclk),
		.i2sData(i2sData)
	);

endmodule

`default_nettype wire

// File: bench/clockGen.sv
// Clock generator for sClk and mClk and the power-on reset
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic sClk,
	output logic mClk,
	output logic rstN
);
	// Both 10 ns with mClk shifted so the domains never share an edge
	initial
	begin
		sClk = 1'b0;
		forever #5 sClk = ~sClk;
	end

	initial
	begin
		mClk = 1'b0;
		#3;
		forever #5 mClk = ~mClk;
	end

	// Released on the fifth mClk edge so each clock sees 5 low cycles
	initial
	begin
		rstN = 1'b0;
		repeat (5) @(posedge mClk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/flashModel.sv
// Behavioural SPI flash model answering the read command from a byte array
`timescale 1ns/100ps
`default_nettype none

module flashModel #(
	parameter int pSize = 64
)(
	input  logic csN,
	input  logic sck,
	input  logic mosi,
	output logic miso
);
	// Plain read opcode of a standard SPI flash
	localparam logic [7:0] readOpcode = 8'h03;

	// Image bytes filled by the testbench
	logic [7:0]  mem [pSize];
	logic [31:0] cmdAddr;
	int          inCnt;
	int          outCnt;
	int          byteIdx;

	initial
	begin
		miso    = 1'b0;
		cmdAddr = '0;
		inCnt   = 0;
		outCnt  = 0;
	end

	// New transaction on every CS fall
	always @(negedge csN)
	begin
		inCnt  = 0;
		outCnt = 0;
	end

	// Command and address bits taken on the rising SCK edge in mode 0
	always @(posedge sck)
	begin
		if (!csN && inCnt < 32)
		begin
			cmdAddr = {cmdAddr[30:0], mosi};
			inCnt++;
		end
	end

	// Data goes out MSB first on the falling edge as the address counts up
	always @(negedge sck)
	begin
		if (!csN && inCnt >= 32)
		begin
			byteIdx = (int'(cmdAddr[23:0]) + outCnt / 8) % pSize;
			// Unknown command leaves MISO pulled high
			if (cmdAddr[31:24] == readOpcode)
				miso = mem[byteIdx][7 - outCnt % 8];
			else
				miso = 1'b1;
			outCnt++;
		end
	end

endmodule

`default_nettype wire

// File: bench/audioTxBench.sv
// Testbench top with file-driven stimulus, I2S capture, compare tasks and watchdog
`timescale 1ns/100ps
`default_nettype none

module audioTxBench;
	import audioPkg::*;
	import flashPkg::*;

	localparam int chans     = 3;
	localparam int imgSize   = 64;
	localparam int testBase  = 'h10;
	localparam int testWords = 8;

	logic                  sClk;
	logic                  mClk;
	logic                  rstN;
	logic [chans-1:0]      play;
	flashAddrT [chans-1:0] startAddr;
	flashAddrT [chans-1:0] endAddr;
	logic [chans-1:0]      busy;
	logic [chans-1:0]      flashSck;
	logic [chans-1:0]      flashMosi;
	logic [chans-1:0]      flashMiso;
	logic [chans-1:0]      flashCsN;
	logic                  i2sBclk;
	logic                  i2sLrclk;
	logic                  i2sData;

	logic [31:0] stim [256];
	logic [31:0] leftQ [$];
	logic [31:0] rightQ [$];
	logic [31:0] capShift;
	logic [31:0] capWord;
	logic [31:0] capLeft;
	logic        prevLr;
	longint      limitNs;
	logic        limitReady;
	int          errCount;
	int          numTests;
	int          totalSamples;

	clockGen u_clockGen (
		.sClk(sClk),
		.mClk(mClk),
		.rstN(rstN)
	);

	audioTxBlock #(
		.pChanNum(chans),
		.pSckDiv(1),
		.pFifoDepth(16)
	) u_audioTxBlock (
		.sClk(sClk),
		.mClk(mClk),
		.rstN(rstN),
		.play(play),
		.startAddr(startAddr),
		.endAddr(endAddr),
		.busy(busy),
		.flashSck(flashSck),
		.flashMosi(flashMosi),
		.flashMiso(flashMiso),
		.flashCsN(flashCsN),
		.i2sBclk(i2sBclk),
		.i2sLrclk(i2sLrclk),
		.i2sData(i2sData)
	);

	flashModel #(.pSize(imgSize)) u_flashModel0 (
		.csN(flashCsN[0]), .sck(flashSck[0]), .mosi(flashMosi[0]), .miso(flashMiso[0])
	);
	flashModel #(.pSize(imgSize)) u_flashModel1 (
		.csN(flashCsN[1]), .sck(flashSck[1]), .mosi(flashMosi[1]), .miso(flashMiso[1])
	);
	flashModel #(.pSize(imgSize)) u_flashModel2 (
		.csN(flashCsN[2]), .sck(flashSck[2]), .mosi(flashMosi[2]), .miso(flashMiso[2])
	);

	// ----------------------------------------
	// Image and test table access
	// ----------------------------------------

	// Chip 0 image at 'h40, chips 1 and 2 at 'h80 and 'hA0 (32 bytes each)
	function automatic logic [7:0] imageByte(input int ch, input int addr);
		int base;
		base = (ch == 0) ? 'h40 : (ch == 1) ? 'h80 : 'hA0;
		if (ch != 0 && addr >= 32)
			return 8'h00;
		return stim[base + addr][7:0];
	endfunction

	// Low byte first in flash
	function automatic sampleT storedSample(input int ch, input int addr);
		return {imageByte(ch, addr + 1), imageByte(ch, addr)};
	endfunction

	// Samples of one channel in a test or zero when it does not play
	function automatic int chanLength(input int t, input int ch);
		int base;
		base = testBase + t * testWords;
		if (!stim[base][ch])
			return 0;
		return (int'(stim[base + 2 + 2 * ch][23:0]) - int'(stim[base + 1 + 2 * ch][23:0]) + 1) / 2;
	endfunction

	// Longest channel sets the frame count
	function automatic int testLength(input int t);
		int n;
		n = 0;
		for (int ch = 0; ch < chans; ch++)
			if (chanLength(t, ch) > n)
				n = chanLength(t, ch);
		return n;
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic stopRun();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkMix(input string name, input mixT got, input mixT exp);
		if (got !== exp)
		begin
			errCount++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkStereo(input logic [31:0] left, input logic [31:0] right);
		if (left !== right)
		begin
			errCount++;
			$display("[ERROR] i2sData right slot got %h expected %h", right, left);
			stopRun();
		end
		if (left[7:0] !== 8'h00)
		begin
			errCount++;
			$display("[ERROR] i2sData pad bits got %h expected %h", left[7:0], 8'h00);
			stopRun();
		end
	endtask

	task automatic checkIdle(input int ch, input logic chanBusy, input logic csN);
		if (chanBusy !== 1'b0)
		begin
			errCount++;
			$display("[ERROR] busy[%0d] got %h expected %h", ch, chanBusy, 1'b0);
			stopRun();
		end
		if (csN !== 1'b1)
		begin
			errCount++;
			$display("[ERROR] flashCsN[%0d] got %h expected %h", ch, csN, 1'b1);
			stopRun();
		end
	endtask

	// ----------------------------------------
	// I2S capture
	// ----------------------------------------

	// LRCLK change seen at a rising edge marks the LSB of the slot just ended
	always @(posedge i2sBclk)
	begin
		capWord = {capShift[30:0], i2sData};
		if (i2sLrclk !== prevLr)
		begin
			if (!prevLr)
				capLeft = capWord;
			else if (capLeft != 0 || capWord != 0)
			begin
				// Underflow frames are all zero and dropped
				leftQ.push_back(capLeft);
				rightQ.push_back(capWord);
			end
		end
		capShift = capWord;
		prevLr   = i2sLrclk;
	end

	// ----------------------------------------
	// One play command and its frames
	// ----------------------------------------
	task automatic runTest(input int t);
		int          base;
		int          n;
		int          cnt [chans];
		flashAddrT   sA [chans];
		flashAddrT   eA [chans];
		mixT         exp;
		logic [31:0] left;
		logic [31:0] right;
		base = testBase + t * testWords;
		n    = testLength(t);
		for (int ch = 0; ch < chans; ch++)
		begin
			sA[ch]  = stim[base + 1 + 2 * ch][23:0];
			eA[ch]  = stim[base + 2 + 2 * ch][23:0];
			cnt[ch] = chanLength(t, ch);
		end

		@(posedge sClk);
		for (int ch = 0; ch < chans; ch++)
		begin
			startAddr[ch] <= sA[ch];
			endAddr[ch]   <= eA[ch];
		end
		play <= stim[base][chans-1:0];
		@(posedge sClk);
		play <= '0;

		for (int k = 0; k < n; k++)
		begin
			// Channels past their end add nothing
			exp = '0;
			for (int ch = 0; ch < chans; ch++)
				if (k < cnt[ch])
					exp = exp + mixT'(storedSample(ch, int'(sA[ch]) + 2 * k));
			while (leftQ.size() == 0)
				@(posedge mClk);
			left  = leftQ.pop_front();
			right = rightQ.pop_front();
			checkStereo(left, right);
			checkMix($sformatf("i2sData left slot test %0d frame %0d", t, k),
				mixT'(left[31:8]), exp);
		end

		// Last sample left the readers long before its frame came out
		@(posedge sClk);
		for (int ch = 0; ch < chans; ch++)
			checkIdle(ch, busy[ch], flashCsN[ch]);
		repeat ($urandom_range(20, 5)) @(posedge sClk);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		play       = '0;
		startAddr  = '0;
		endAddr    = '0;
		capShift   = '0;
		capLeft    = '0;
		prevLr     = 1'b0;
		errCount   = 0;
		limitReady = 1'b0;
		void'($urandom(32'hafa6));

		$readmemh("bench/audioInput.hex", stim);
		numTests = stim[0];
		for (int i = 0; i < imgSize; i++)
		begin
			u_flashModel0.mem[i] = imageByte(0, i);
			u_flashModel1.mem[i] = imageByte(1, i);
			u_flashModel2.mem[i] = imageByte(2, i);
		end

		// One frame is 64 BCLK of 4 mClk with a factor of two plus margin
		totalSamples = 0;
		for (int t = 0; t < numTests; t++)
			totalSamples += testLength(t);
		limitNs    = longint'(totalSamples) * 64 * 4 * 2 * 10 + 100000;
		limitReady = 1'b1;

		wait (rstN === 1'b1);
		repeat (2) @(posedge sClk);
		for (int t = 0; t < numTests; t++)
			runTest(t);

		// Nothing may follow the last expected frame
		repeat (3 * 256) @(posedge mClk);
		if (leftQ.size() != 0)
		begin
			errCount++;
			$display("Extra frames arrived after the last test: %0d", leftQ.size());
		end

		if (errCount == 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
			stopRun();
	end

	// Watchdog
	initial
	begin
		wait (limitReady === 1'b1);
		#(limitNs);
		$display("Timeout: the I2S output did not deliver all frames in time");
		stopRun();
	end

endmodule

`default_nettype wire

// File: all.f
design/audioPkg.sv
design/flashPkg.sv
design/flashReader.sv
design/sampleMixer.sv
design/asyncFifo.sv
design/i2sTransmitter.sv
design/audioTxBlock.sv
bench/clockGen.sv
bench/flashModel.sv
bench/audioTxBench.sv

// File: bench/audioInput.hex
// @00 test count; @10 tests, 8 words each: play mask, start0 end0, start1 end1, start2 end2, pad
// @40 chip 0 image (64 bytes), @80 chip 1 image, @A0 chip 2 image (32 bytes each)
@00
00000005
@10
00000001 00000000 00000007 00000000 00000000 00000000 00000000 00000000
00000007 00000008 0000000F 00000000 00000007 00000000 00000007 00000000
00000007 00000010 00000017 00000008 0000000B 00000008 0000000D 00000000
00000001 00000018 0000003F 00000000 00000000 00000000 00000000 00000000
00000006 00000000 00000000 00000010 0000001F 00000010 0000001F 00000000
// Chip 0, single channel, wide sums, different lengths, long range
@40
34 12 DC FE FF 7F 01 00 00 80 BC 9A 00 70 01 C0
00 01 00 02 00 03 00 04 11 01 22 02 33 03 44 04
55 05 66 06 77 07 88 08 99 09 AA 0A BB 0B CC 0C
DD 0D EE 0E FF 0F 10 F0 21 E1 32 D2 43 C3 54 B4
// Chip 1
@80
00 90 01 80 00 70 00 C0 10 00 20 00 5A A5 5A A5
01 10 02 20 03 30 04 40 05 50 06 60 07 70 08 78
// Chip 2
@A0
00 A0 00 80 FF 7F 00 C0 00 10 00 20 00 30 77 77
01 01 02 02 03 03 04 04 05 05 06 06 07 07 08 08
